//--- dv/bip_tests.txt
// one record per two lines, all hex: program length then the program words,
// then peripheral input word, write count, (address data) pairs, final pc
// ldi and sto, positive and negative immediates
0007 1923 0C05 1FFB 0C0A 1C00 0FFF 0000
0000 0003 0005 0123 000A FFFB 03FF FC00 0006
// addi and subi, including a wrap through zero
000B 1BFF 2BFF 2C00 3FFF 3A00 0C01 1FFF 2801 3803 0C02 0000
0000 0002 0001 01FF 0002 FFFD 000A
// ram round trip with ld, add and sub, only the last sto hits the window
000F 1955 0810 1864 0811 1800 1010 2011 2010 3011 0BFF 1800 23FF 382A 0FF0 0000
BEEF 0001 03F0 0280 000E
// peripheral read written back into the window
0006 1412 0C13 3412 2807 0C14 0000
A5C3 0002 0013 A5C3 0014 0007 0005
// halt at address zero
0001 0000
0000 0000 0000
// unused opcode stops like a halt
0003 1805 0C20 F800
0000 0001 0020 0005 0002
// end of file
0000

//--- bip_top.f
src/bip_pkg.sv
src/bip_program_memory.sv
src/bip_mem_io.sv
src/bip_control.sv
src/bip_datapath.sv
src/bip_cpu.sv
src/bip_top.sv
dv/bip_clock_gen.sv
dv/bip_tb.sv

//--- dv/bip_tb.sv
`timescale 1ns/100ps
`default_nettype none

module bip_tb;

   import bip_pkg::*;

   localparam int file_depth = 256;

   logic        clk;
   logic        reset;
   logic        prog_mode;
   logic        prog_we;
   ins_addr_t   prog_addr;
   data_word_t  prog_data;
   data_word_t  per_data_in;
   ins_addr_t   pc;
   logic        halted;
   logic        cs_perif;
   logic        w_r_per;
   perif_addr_t addr_bus_per;
   data_word_t  per_data_out;

   data_word_t  tests [file_depth];  // records from dv/bip_tests.txt
   int          word_count;
   int          cycle_count = 0;
   int          cycle_limit = 0;     // 0 until the file is read
   int          ptr;                 // start of the current record

   bip_clock_gen u_clock_gen (
      .o_clk (clk)
   );

   bip_top dut (
      .i_clk          (clk),
      .i_reset        (reset),
      .i_prog_mode    (prog_mode),
      .i_prog_we      (prog_we),
      .i_prog_addr    (prog_addr),
      .i_prog_data    (prog_data),
      .o_pc           (pc),
      .o_halted       (halted),
      .o_cs_perif     (cs_perif),
      .o_w_r_per      (w_r_per),
      .o_addr_bus_per (addr_bus_per),
      .o_per_data     (per_data_out),
      .i_per_data     (per_data_in)
   );

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failures found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input data_word_t got, input data_word_t exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_perif_addr(input perif_addr_t got, input perif_addr_t exp,
                                   input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_pc(input ins_addr_t got, input ins_addr_t exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   // load one program, run it to the halt and check the window writes
   task automatic run_record();
      int        len;
      int        i;
      int        pair_base;
      int        expected_writes;
      int        writes_seen;
      int        run_cycles;
      logic      done;
      ins_addr_t exp_pc;
      len             = int'(tests[ptr]);
      expected_writes = int'(tests[ptr + len + 2]);
      pair_base       = ptr + len + 3;
      exp_pc          = ins_addr_t'(tests[pair_base + 2 * expected_writes]);
      if (pair_base + 2 * expected_writes >= word_count) begin
         fail_run("The data file ends in the middle of a test record.");
      end
      @(posedge clk);
      prog_mode   <= 1'b1;
      per_data_in <= tests[ptr + len + 1];  // held for the whole record
      for (i = 0; i < len; i++) begin
         prog_we   <= 1'b1;
         prog_addr <= ins_addr_t'(i);
         prog_data <= tests[ptr + 1 + i];
         @(posedge clk);
      end
      prog_we <= 1'b0;
      @(negedge clk);
      check_flag(halted, 1'b0, "o_halted in program mode");
      check_pc(pc, '0, "o_pc in program mode");
      @(posedge clk);
      prog_mode   <= 1'b0;
      writes_seen = 0;
      run_cycles  = 0;
      done        = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (run_cycles == 0) begin
            check_pc(pc, '0, "o_pc at start of run");
         end
         if (halted) begin
            done = 1'b1;
         end else if (cs_perif && w_r_per) begin
            if (writes_seen >= expected_writes) begin
               fail_run("The CPU wrote to the peripheral window more often than expected.");
            end
            check_perif_addr(addr_bus_per, perif_addr_t'(tests[pair_base + 2 * writes_seen]),
                             "o_addr_bus_per");
            check_word(per_data_out, tests[pair_base + 2 * writes_seen + 1], "o_per_data");
            writes_seen++;
         end
         run_cycles++;
      end
      if (writes_seen != expected_writes) begin
         fail_run($sformatf("The CPU halted with %0d peripheral writes still expected.",
                            expected_writes - writes_seen));
      end
      check_pc(pc, exp_pc, "o_pc after halt");
      repeat (4) begin  // halt must hold
         @(negedge clk);
         check_flag(halted, 1'b1, "o_halted");
         check_pc(pc, exp_pc, "o_pc while halted");
         check_flag(cs_perif, 1'b0, "o_cs_perif while halted");
      end
      ptr = pair_base + 2 * expected_writes + 1;
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         fail_run($sformatf("The run timed out after %0d cycles.", cycle_count));
      end
   end

   initial begin
      reset       <= 1'b1;
      prog_mode   <= 1'b0;
      prog_we     <= 1'b0;
      prog_addr   <= '0;
      prog_data   <= '0;
      per_data_in <= '0;
      $readmemh("dv/bip_tests.txt", tests);
      word_count = 0;
      while (word_count < file_depth && !$isunknown(tests[word_count])) begin
         word_count++;
      end
      if (word_count == 0) begin
         fail_run("No words could be read from dv/bip_tests.txt.");
      end
      cycle_limit = 4 * word_count + 100;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_flag(cs_perif, 1'b0, "o_cs_perif after reset");
      check_flag(w_r_per, 1'b0, "o_w_r_per after reset");
      check_flag(halted, 1'b0, "o_halted after reset");
      check_pc(pc, '0, "o_pc after reset");
      ptr = 0;
      while (tests[ptr] != '0) begin  // zero length ends the file
         run_record();
         if (ptr >= word_count) begin
            fail_run("The data file has no zero-length record at its end.");
         end
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/bip_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module bip_clock_gen (
   output logic o_clk
);

   localparam int half_period = 50;  // 100 ns clock

   initial begin
      o_clk = 1'b0;
   end

   always begin
      #(half_period) o_clk = ~o_clk;
   end

endmodule

`default_nettype wire

//--- src/bip_top.sv
`timescale 1ns/100ps
`default_nettype none

module bip_top (
   input  wire                      i_clk,
   input  wire                      i_reset,
   input  wire                      i_prog_mode,
   input  wire                      i_prog_we,
   input  wire bip_pkg::ins_addr_t  i_prog_addr,
   input  wire bip_pkg::data_word_t i_prog_data,
   output bip_pkg::ins_addr_t       o_pc,
   output logic                     o_halted,
   output logic                     o_cs_perif,
   output logic                     o_w_r_per,
   output bip_pkg::perif_addr_t     o_addr_bus_per,
   output bip_pkg::data_word_t      o_per_data,
   input  wire bip_pkg::data_word_t i_per_data
);

   import bip_pkg::*;

   data_word_t instruction;
   data_word_t data_mem_to_cpu;
   data_word_t data_cpu_to_mem;
   data_addr_t addr_data;
   logic       wr;
   logic       rd;

   bip_cpu u_cpu (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_prog_mode   (i_prog_mode),
      .i_instruction (instruction),
      .i_data_mem    (data_mem_to_cpu),
      .o_addr_ins    (o_pc),  // pc is also the fetch address
      .o_halted      (o_halted),
      .o_addr_data   (addr_data),
      .o_data        (data_cpu_to_mem),
      .o_wr          (wr),
      .o_rd          (rd)
   );

   bip_program_memory u_program_memory (
      .i_clk         (i_clk),
      .i_prog_we     (i_prog_we),
      .i_prog_addr   (i_prog_addr),
      .i_prog_data   (i_prog_data),
      .i_addr        (o_pc),
      .o_instruction (instruction)
   );

   bip_mem_io u_mem_io (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_addr         (addr_data),
      .i_data         (data_cpu_to_mem),
      .i_wr           (wr),
      .i_rd           (rd),
      .i_per_data     (i_per_data),
      .o_rdata        (data_mem_to_cpu),
      .o_cs_perif     (o_cs_perif),
      .o_w_r_per      (o_w_r_per),
      .o_addr_bus_per (o_addr_bus_per),
      .o_per_data     (o_per_data)
   );

endmodule

`default_nettype wire

//--- src/bip_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module bip_cpu (
   input  wire                      i_clk,
   input  wire                      i_reset,
   input  wire                      i_prog_mode,
   input  wire bip_pkg::data_word_t i_instruction,
   input  wire bip_pkg::data_word_t i_data_mem,
   output bip_pkg::ins_addr_t       o_addr_ins,
   output logic                     o_halted,
   output bip_pkg::data_addr_t      o_addr_data,
   output bip_pkg::data_word_t      o_data,
   output logic                     o_wr,
   output logic                     o_rd
);

   import bip_pkg::*;

   operand_t operand;
   logic     sel_imm;
   logic     sel_mem;
   logic     acc_we;
   logic     sub;

   bip_control u_control (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_prog_mode   (i_prog_mode),
      .i_instruction (i_instruction),
      .o_pc          (o_addr_ins),
      .o_halted      (o_halted),
      .o_operand     (operand),
      .o_sel_imm     (sel_imm),
      .o_sel_mem     (sel_mem),
      .o_acc_we      (acc_we),
      .o_sub         (sub),
      .o_wr          (o_wr),
      .o_rd          (o_rd)
   );

   bip_datapath u_datapath (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_operand   (operand),
      .i_sel_imm   (sel_imm),
      .i_sel_mem   (sel_mem),
      .i_acc_we    (acc_we),
      .i_sub       (sub),
      .i_mem_data  (i_data_mem),
      .o_acc       (o_data),  // accumulator is the store data
      .o_addr_data (o_addr_data)
   );

endmodule

`default_nettype wire

//--- src/bip_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module bip_datapath (
   input  wire                      i_clk,
   input  wire                      i_reset,
   input  wire bip_pkg::operand_t   i_operand,
   input  wire                      i_sel_imm,
   input  wire                      i_sel_mem,
   input  wire                      i_acc_we,
   input  wire                      i_sub,
   input  wire bip_pkg::data_word_t i_mem_data,
   output bip_pkg::data_word_t      o_acc,
   output bip_pkg::data_addr_t      o_addr_data
);

   import bip_pkg::*;

   data_word_t acc;
   data_word_t imm_ext;
   data_word_t operand_word;
   data_word_t alu_out;
   data_word_t acc_next;

   // 11-bit signed immediate to full word
   assign imm_ext = {{(data_width-operand_width){i_operand[operand_width-1]}}, i_operand};

   // direct addressing, the operand is the address
   assign o_addr_data = i_operand;

   assign operand_word = i_sel_imm ? imm_ext : i_mem_data;

   // wraps mod 2^16
   always_comb begin
      if (i_sub) begin
         alu_out = acc - operand_word;
      end else begin
         alu_out = acc + operand_word;
      end
   end

   // loads bypass the adder
   assign acc_next = i_sel_mem ? operand_word : alu_out;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         acc <= '0;
      end else if (i_acc_we) begin
         acc <= acc_next;
      end
   end

   assign o_acc = acc;  // also the store data

endmodule

`default_nettype wire

//--- src/bip_control.sv
`timescale 1ns/100ps
`default_nettype none

module bip_control (
   input  wire                      i_clk,
   input  wire                      i_reset,
   input  wire                      i_prog_mode,
   input  wire bip_pkg::data_word_t i_instruction,
   output bip_pkg::ins_addr_t       o_pc,
   output logic                     o_halted,
   output bip_pkg::operand_t        o_operand,
   output logic                     o_sel_imm,
   output logic                     o_sel_mem,
   output logic                     o_acc_we,
   output logic                     o_sub,
   output logic                     o_wr,
   output logic                     o_rd
);

   import bip_pkg::*;

   cpu_state_t state;
   ins_addr_t  pc;
   opcode_t    opcode;
   logic       run;       // core is allowed to execute this cycle
   logic       halt_op;
   logic       acc_we_op;
   logic       wr_op;
   logic       rd_op;

   assign opcode    = opcode_t'(i_instruction[data_width-1 -: opcode_width]);
   assign o_operand = i_instruction[operand_width-1:0];
   assign run       = (state == st_run) && !i_prog_mode;

   always_comb begin
      halt_op   = 1'b0;
      acc_we_op = 1'b0;
      wr_op     = 1'b0;
      rd_op     = 1'b0;
      o_sel_imm = 1'b0;  // operand from memory word
      o_sel_mem = 1'b0;  // acc from adder
      o_sub     = 1'b0;
      case (opcode)
         op_sto: wr_op = 1'b1;
         op_ld: begin
            rd_op     = 1'b1;
            o_sel_mem = 1'b1;
            acc_we_op = 1'b1;
         end
         op_ldi: begin
            o_sel_imm = 1'b1;
            o_sel_mem = 1'b1;
            acc_we_op = 1'b1;
         end
         op_add: begin
            rd_op     = 1'b1;
            acc_we_op = 1'b1;
         end
         op_addi: begin
            o_sel_imm = 1'b1;
            acc_we_op = 1'b1;
         end
         op_sub: begin
            rd_op     = 1'b1;
            o_sub     = 1'b1;
            acc_we_op = 1'b1;
         end
         op_subi: begin
            o_sel_imm = 1'b1;
            o_sub     = 1'b1;
            acc_we_op = 1'b1;
         end
         default: halt_op = 1'b1;  // HLT and unused codes
      endcase
   end

   // no side effects while halted or loading
   assign o_acc_we = run && acc_we_op;
   assign o_wr     = run && wr_op;
   assign o_rd     = run && rd_op;

   always_ff @(posedge i_clk) begin
      if (i_reset || i_prog_mode) begin
         pc    <= '0;
         state <= st_run;
      end else if (state == st_run) begin
         if (halt_op) begin
            state <= st_halt;  // pc stays on the HLT word
         end else begin
            pc <= pc + ins_addr_t'(1);
         end
      end
   end

   assign o_pc     = pc;
   assign o_halted = (state == st_halt);

   a_pc_frozen_in_halt : assert property (
      @(posedge i_clk) disable iff (i_reset)
      (state == st_halt && !i_prog_mode) |=> (pc == $past(pc))
   );

endmodule

`default_nettype wire

//--- src/bip_mem_io.sv
`timescale 1ns/100ps
`default_nettype none

module bip_mem_io (
   input  wire                      i_clk,
   input  wire                      i_reset,
   input  wire bip_pkg::data_addr_t i_addr,
   input  wire bip_pkg::data_word_t i_data,
   input  wire                      i_wr,
   input  wire                      i_rd,
   input  wire bip_pkg::data_word_t i_per_data,
   output bip_pkg::data_word_t      o_rdata,
   output logic                     o_cs_perif,
   output logic                     o_w_r_per,
   output bip_pkg::perif_addr_t     o_addr_bus_per,
   output bip_pkg::data_word_t      o_per_data
);

   import bip_pkg::*;

   data_word_t  ram [ram_depth];  // data RAM, lower half of the map
   logic        is_perif;
   perif_addr_t low_addr;

   assign is_perif = i_addr[perif_sel_bit];
   assign low_addr = i_addr[perif_sel_bit-1:0];  // same offset for RAM and window

   always_ff @(posedge i_clk) begin
      if (i_wr && !is_perif) begin
         ram[low_addr] <= i_data;
      end
   end

   // read word back in the same cycle
   assign o_rdata = is_perif ? i_per_data : ram[low_addr];

   // peripheral strobes only for real accesses into the window
   assign o_cs_perif     = is_perif && (i_wr || i_rd);
   assign o_w_r_per      = is_perif && i_wr;  // 1 write, 0 read
   assign o_addr_bus_per = low_addr;
   assign o_per_data     = i_data;

   // control never asks for a read and a write of the same word
   a_wr_rd_excl : assert property (
      @(posedge i_clk) disable iff (i_reset)
      !(i_wr && i_rd)
   );

endmodule

`default_nettype wire

//--- src/bip_program_memory.sv
`timescale 1ns/100ps
`default_nettype none

module bip_program_memory (
   input  wire                 i_clk,
   input  wire                 i_prog_we,
   input  wire bip_pkg::ins_addr_t  i_prog_addr,
   input  wire bip_pkg::data_word_t i_prog_data,
   input  wire bip_pkg::ins_addr_t  i_addr,
   output bip_pkg::data_word_t      o_instruction
);

   import bip_pkg::*;

   data_word_t mem [ins_depth];  // instruction store

   // load port, one word per strobe
   always_ff @(posedge i_clk) begin
      if (i_prog_we) begin
         mem[i_prog_addr] <= i_prog_data;
      end
   end

   // fetch is asynchronous so an instruction runs in the cycle it is addressed
   assign o_instruction = mem[i_addr];

endmodule

`default_nettype wire

//--- src/bip_pkg.sv
`default_nettype none

package bip_pkg;

   localparam int data_width    = 16;
   localparam int ins_depth     = 2048;
   localparam int data_depth    = 2048;
   localparam int ram_depth     = 1024;  // lower half of the data space
   localparam int operand_width = 11;
   localparam int opcode_width  = 5;

   localparam int ins_addr_width   = $clog2(ins_depth);
   localparam int data_addr_width  = $clog2(data_depth);
   localparam int perif_addr_width = $clog2(ram_depth);

   // data address bit that picks the peripheral window
   localparam int perif_sel_bit = perif_addr_width;

   typedef logic [data_width-1:0]       data_word_t;
   typedef logic [ins_addr_width-1:0]   ins_addr_t;
   typedef logic [data_addr_width-1:0]  data_addr_t;
   typedef logic [perif_addr_width-1:0] perif_addr_t;
   typedef logic [operand_width-1:0]    operand_t;

   // unlisted codes decode as op_hlt
   typedef enum logic [opcode_width-1:0] {
      op_hlt  = 5'd0,
      op_sto  = 5'd1,
      op_ld   = 5'd2,
      op_ldi  = 5'd3,
      op_add  = 5'd4,
      op_addi = 5'd5,
      op_sub  = 5'd6,
      op_subi = 5'd7
   } opcode_t;

   typedef enum logic {
      st_run,
      st_halt
   } cpu_state_t;

endpackage

`default_nettype wire
